/* rob_bank.sv */
/*
 One reorder buffer bank, a first-word-fall-through queue of slots.
 Keeps completion tags per slot; the head entry is always on the outputs.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_bank
   import rob_geom_pkg::*;
   import rob_uop_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   input  logic      push,
   input  logic      pop,
   input  pc_t       push_pc,
   input  lreg_t     push_lrd,
   input  preg_t     push_prd,
   input  logic      push_prd_we,
   input  preg_t     push_pfree,
   input  logic      wb_we,
   input  slot_idx_t wb_slot,
   input  logic      wb_exc,
   input  logic      wb_fls,
   input  pc_t       wb_fls_tgt,
   output logic      valid,
   output logic      full,
   output logic      done,
   output slot_idx_t wptr,
   output pc_t       head_pc,
   output lreg_t     head_lrd,
   output preg_t     head_prd,
   output logic      head_prd_we,
   output preg_t     head_pfree,
   output logic      head_exc,
   output logic      head_fls,
   output pc_t       head_fls_tgt
);

   localparam int SLOTS = 1 << `ROB_SLOT_AW;

   pc_t   pc_mem [SLOTS];
   lreg_t lrd_mem [SLOTS];
   preg_t prd_mem [SLOTS];
   logic  prd_we_mem [SLOTS];
   preg_t pfree_mem [SLOTS];
   pc_t   tgt_mem [SLOTS];
   // Completion tags per slot
   logic [SLOTS-1:0] done_q;
   logic [SLOTS-1:0] exc_q;
   logic [SLOTS-1:0] fls_q;
   slot_idx_t rptr_q;
   slot_idx_t wptr_q;
   logic [`ROB_SLOT_AW:0] cnt_q;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         rptr_q <= '0;
         wptr_q <= '0;
         cnt_q  <= '0;
      end
      else
      begin
         if (push)
            wptr_q <= wptr_q + 1'b1;
         if (pop)
            rptr_q <= rptr_q + 1'b1;
         cnt_q <= cnt_q + push - pop;
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         pc_mem[wptr_q]     <= push_pc;
         lrd_mem[wptr_q]    <= push_lrd;
         prd_mem[wptr_q]    <= push_prd;
         prd_we_mem[wptr_q] <= push_prd_we;
         pfree_mem[wptr_q]  <= push_pfree;
      end
      if (wb_we)
         tgt_mem[wb_slot] <= wb_fls_tgt;
   end

   // New entries start incomplete, writeback marks them done
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         done_q <= '0;
         exc_q  <= '0;
         fls_q  <= '0;
      end
      else
      begin
         if (push)
         begin
            done_q[wptr_q] <= 1'b0;
            exc_q[wptr_q]  <= 1'b0;
            fls_q[wptr_q]  <= 1'b0;
         end
         if (wb_we)
         begin
            done_q[wb_slot] <= 1'b1;
            exc_q[wb_slot]  <= wb_exc;
            fls_q[wb_slot]  <= wb_fls;
         end
      end
   end

   assign valid = (cnt_q != '0);
   assign full  = (cnt_q == SLOTS[`ROB_SLOT_AW:0]);
   assign wptr  = wptr_q;
   assign done  = done_q[rptr_q];

   assign head_pc      = pc_mem[rptr_q];
   assign head_lrd     = lrd_mem[rptr_q];
   assign head_prd     = prd_mem[rptr_q];
   assign head_prd_we  = prd_we_mem[rptr_q];
   assign head_pfree   = pfree_mem[rptr_q];
   assign head_exc     = exc_q[rptr_q];
   assign head_fls     = fls_q[rptr_q];
   assign head_fls_tgt = tgt_mem[rptr_q];

   // Pushes are gated upstream by rob_ready
   a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n || flush)
      push |-> !full);

   // Pops come from the commit chain, which only sees occupied heads
   a_no_pop_empty : assert property (@(posedge clk) disable iff (!rst_n || flush)
      pop |-> valid);

endmodule

/* rob_ctrl.sv */
/*
 Head and tail bank pointers of the reorder buffer.
 Decodes push and pop counts into bank strobes and forms the in-order commit chain.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_ctrl
   import rob_geom_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   input  lane_cnt_t push_size,
   input  lane_cnt_t pop_size,
   input  logic      bank_full [`ROB_LANES],
   input  logic      bank_valid [`ROB_LANES],
   input  logic      bank_done [`ROB_LANES],
   input  slot_idx_t bank_wptr [`ROB_LANES],
   output bank_idx_t head_bank,
   output bank_idx_t tail_bank,
   output logic      bank_push [`ROB_LANES],
   output logic      bank_pop [`ROB_LANES],
   output logic      rob_ready,
   output bank_idx_t free_bank [`ROB_LANES],
   output slot_idx_t free_id [`ROB_LANES],
   output logic      cmt_valid [`ROB_LANES]
);

   bank_idx_t head_q;
   bank_idx_t tail_q;
   // Distance of each bank from the tail and from the head
   bank_idx_t tail_off [`ROB_LANES];
   bank_idx_t head_off [`ROB_LANES];
   // Bank seen by each commit lane
   bank_idx_t lane_bank [`ROB_LANES];
   logic      ent_valid [`ROB_LANES];
   lane_cnt_t cmt_cnt;

   always_ff @(posedge clk)
   begin
      if (!rst_n || flush)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else
      begin
         // Entries alternate banks, so pointers advance modulo the bank count
         head_q <= head_q + bank_idx_t'(pop_size);
         tail_q <= tail_q + bank_idx_t'(push_size);
      end
   end

   assign head_bank = head_q;
   assign tail_bank = tail_q;

   always_comb
   begin
      for (int b = 0; b < `ROB_LANES; b++)
      begin
         tail_off[b]  = bank_idx_t'(b) - tail_q;
         head_off[b]  = bank_idx_t'(b) - head_q;
         bank_push[b] = lane_cnt_t'(tail_off[b]) < push_size;
         bank_pop[b]  = lane_cnt_t'(head_off[b]) < pop_size;
      end
   end

   // Where each issue lane lands this cycle
   always_comb
   begin
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         free_bank[i] = tail_q + bank_idx_t'(i);
         free_id[i]   = bank_wptr[tail_q + bank_idx_t'(i)];
      end
   end

   always_comb
   begin
      rob_ready = 1'b1;
      for (int b = 0; b < `ROB_LANES; b++)
      begin
         lane_bank[b] = head_q + bank_idx_t'(b);
         ent_valid[b] = bank_valid[lane_bank[b]] & bank_done[lane_bank[b]];
         rob_ready    = rob_ready & ~bank_full[b];
      end
   end

   // A younger lane commits only behind a committing older lane
   always_comb
   begin
      cmt_valid[0] = ent_valid[0];
      cmt_cnt      = lane_cnt_t'(ent_valid[0]);
      for (int i = 1; i < `ROB_LANES; i++)
      begin
         cmt_valid[i] = cmt_valid[i-1] & ent_valid[i];
         cmt_cnt      = cmt_cnt + lane_cnt_t'(cmt_valid[i]);
      end
   end

   // Issue holds off while any bank is full
   a_push_ready : assert property (@(posedge clk) disable iff (!rst_n || flush)
      (push_size != '0) |-> rob_ready);

   // Commit pops only lanes it was shown as valid
   a_pop_bound : assert property (@(posedge clk) disable iff (!rst_n || flush)
      pop_size <= cmt_cnt);

endmodule

/* rob_defines.svh */
/*
 Shape and field widths of the banked reorder buffer.
 Include wherever lane counts, slot depth or register widths are needed.
*/
`ifndef ROB_DEFINES_SVH
`define ROB_DEFINES_SVH

// Issue, writeback and commit lanes, one bank per lane
`define ROB_LANES   2

// Each bank holds 2**ROB_SLOT_AW slots
`define ROB_SLOT_AW 2

`define ROB_PC_W    32
`define ROB_LRF_AW  5
`define ROB_PRF_AW  6

`endif

/* rob_geom_pkg.sv */
/*
 Index and count types for the banked layout of the reorder buffer.
 Used by every block that addresses banks, slots or lane counts.
*/
`include "rob_defines.svh"

package rob_geom_pkg;

   // Bank number, one bank per commit lane
   typedef logic [$clog2(`ROB_LANES)-1:0] bank_idx_t;

   // Slot within one bank
   typedef logic [`ROB_SLOT_AW-1:0] slot_idx_t;

   // Zero up to ROB_LANES lanes
   typedef logic [$clog2(`ROB_LANES+1)-1:0] lane_cnt_t;

endpackage

/* rob_lane_xbar.sv */
/*
 Lane to bank crossbar of the reorder buffer.
 Rotates issue lanes onto banks from the tail and bank heads onto commit lanes.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_lane_xbar
   import rob_geom_pkg::*;
   import rob_uop_pkg::*;
(
   input  bank_idx_t tail_bank,
   input  bank_idx_t head_bank,
   input  pc_t       push_pc [`ROB_LANES],
   input  lreg_t     push_lrd [`ROB_LANES],
   input  preg_t     push_prd [`ROB_LANES],
   input  logic      push_prd_we [`ROB_LANES],
   input  preg_t     push_pfree [`ROB_LANES],
   input  pc_t       head_pc [`ROB_LANES],
   input  lreg_t     head_lrd [`ROB_LANES],
   input  preg_t     head_prd [`ROB_LANES],
   input  logic      head_prd_we [`ROB_LANES],
   input  preg_t     head_pfree [`ROB_LANES],
   input  logic      head_exc [`ROB_LANES],
   input  logic      head_fls [`ROB_LANES],
   input  pc_t       head_fls_tgt [`ROB_LANES],
   output pc_t       bank_pc [`ROB_LANES],
   output lreg_t     bank_lrd [`ROB_LANES],
   output preg_t     bank_prd [`ROB_LANES],
   output logic      bank_prd_we [`ROB_LANES],
   output preg_t     bank_pfree [`ROB_LANES],
   output pc_t       cmt_pc [`ROB_LANES],
   output lreg_t     cmt_lrd [`ROB_LANES],
   output preg_t     cmt_prd [`ROB_LANES],
   output logic      cmt_prd_we [`ROB_LANES],
   output preg_t     cmt_pfree [`ROB_LANES],
   output logic      cmt_exc [`ROB_LANES],
   output logic      cmt_fls [`ROB_LANES],
   output pc_t       cmt_fls_tgt [`ROB_LANES]
);

   // Issue lane feeding each bank
   bank_idx_t src_lane [`ROB_LANES];
   // Bank read by each commit lane
   bank_idx_t src_bank [`ROB_LANES];

   // Oldest issue lane goes to the tail bank
   always_comb
   begin
      for (int b = 0; b < `ROB_LANES; b++)
      begin
         src_lane[b]    = bank_idx_t'(b) - tail_bank;
         bank_pc[b]     = push_pc[src_lane[b]];
         bank_lrd[b]    = push_lrd[src_lane[b]];
         bank_prd[b]    = push_prd[src_lane[b]];
         bank_prd_we[b] = push_prd_we[src_lane[b]];
         bank_pfree[b]  = push_pfree[src_lane[b]];
      end
   end

   // Commit lane 0 is the head bank, the oldest entry
   always_comb
   begin
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         src_bank[i]    = head_bank + bank_idx_t'(i);
         cmt_pc[i]      = head_pc[src_bank[i]];
         cmt_lrd[i]     = head_lrd[src_bank[i]];
         cmt_prd[i]     = head_prd[src_bank[i]];
         cmt_prd_we[i]  = head_prd_we[src_bank[i]];
         cmt_pfree[i]   = head_pfree[src_bank[i]];
         cmt_exc[i]     = head_exc[src_bank[i]];
         cmt_fls[i]     = head_fls[src_bank[i]];
         cmt_fls_tgt[i] = head_fls_tgt[src_bank[i]];
      end
   end

endmodule

/* rob_stim.txt */
// c=flush,push,pop pc0 pc1 w=valid,bank,id,exc,fls tgt (port 0 then port 1)
// xa=rob_ready,wb_rdy0,wb_rdy1 xf=fb0,fi0,fb1,fi1 ce=cv0,cv1,exc0,fls0,exc1,fls1 cmt_pc0/1 tgt0/1
000 000 000 00000 000 00000 000 111 0010 000000 000 000 000 000
010 100 000 00000 000 00000 000 111 0010 000000 000 000 000 000
000 000 000 00000 000 00000 000 111 1001 000000 000 000 000 000
020 104 108 00000 000 00000 000 111 1001 000000 000 000 000 000
000 000 000 00000 000 00000 000 111 1102 000000 000 000 000 000
000 000 000 11000 000 00000 000 111 1102 000000 000 000 000 000
000 000 000 00000 000 00000 000 111 1102 000000 000 000 000 000
000 000 000 10000 000 00000 000 110 1102 000000 000 000 000 000
002 000 000 00000 000 00000 000 111 1102 110000 100 104 000 000
020 10c 110 00000 000 00000 000 111 1102 000000 000 000 000 000
000 000 000 10111 200 10200 000 110 1203 000000 000 000 000 000
000 000 000 11101 300 10200 000 111 1203 101100 108 000 200 000
001 000 000 00000 000 00000 000 111 1203 111101 108 10c 200 300
002 000 000 00000 000 00000 000 111 1203 110100 10c 110 300 000
000 000 000 00000 000 00000 000 111 1203 000000 000 000 000 000
020 200 204 00000 000 00000 000 111 1203 000000 000 000 000 000
020 208 20c 00000 000 00000 000 111 1300 000000 000 000 000 000
020 210 214 00000 000 00000 000 111 1001 000000 000 000 000 000
020 218 21c 00000 000 00000 000 111 1102 000000 000 000 000 000
000 000 000 00000 000 00000 000 011 1203 000000 000 000 000 000
000 000 000 11200 000 10310 000 011 1203 000000 000 000 000 000
002 000 000 00000 000 00000 000 011 1203 110010 200 204 000 000
000 000 000 00000 000 00000 000 111 1203 000000 000 000 000 000
000 000 000 11300 000 10001 400 111 1203 000000 000 000 000 000
010 220 000 00000 000 00000 000 111 1203 110001 208 20c 000 400
100 000 000 00000 000 00000 000 011 0313 110001 208 20c 000 400
000 000 000 00000 000 00000 000 111 0010 000000 000 000 000 000
020 300 304 00000 000 00000 000 111 0010 000000 000 000 000 000
000 000 000 11011 500 00000 000 111 0111 000000 000 000 000 000
000 000 000 10000 000 00000 000 110 0111 000000 000 000 000 000
002 000 000 00000 000 00000 000 111 0111 110011 300 304 000 500
000 000 000 00000 000 00000 000 111 0111 000000 000 000 000 000
fff

/* rob_top.sv */
/*
 Banked reorder buffer, two banks of four slots.
 Issue pushes up to two entries, writeback completes them, commit pops in order.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_top
   import rob_geom_pkg::*;
   import rob_uop_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  logic      flush,
   // Issue
   input  lane_cnt_t push_size,
   input  pc_t       push_pc [`ROB_LANES],
   input  lreg_t     push_lrd [`ROB_LANES],
   input  preg_t     push_prd [`ROB_LANES],
   input  logic      push_prd_we [`ROB_LANES],
   input  preg_t     push_pfree [`ROB_LANES],
   output logic      rob_ready,
   output bank_idx_t free_bank [`ROB_LANES],
   output slot_idx_t free_id [`ROB_LANES],
   // Writeback
   input  logic      wb_valid [`ROB_LANES],
   input  bank_idx_t wb_bank [`ROB_LANES],
   input  slot_idx_t wb_id [`ROB_LANES],
   input  logic      wb_exc [`ROB_LANES],
   input  logic      wb_fls [`ROB_LANES],
   input  pc_t       wb_fls_tgt [`ROB_LANES],
   output logic      wb_rob_ready [`ROB_LANES],
   // Commit
   output logic      cmt_valid [`ROB_LANES],
   output pc_t       cmt_pc [`ROB_LANES],
   output lreg_t     cmt_lrd [`ROB_LANES],
   output preg_t     cmt_prd [`ROB_LANES],
   output logic      cmt_prd_we [`ROB_LANES],
   output preg_t     cmt_pfree [`ROB_LANES],
   output logic      cmt_exc [`ROB_LANES],
   output logic      cmt_fls [`ROB_LANES],
   output pc_t       cmt_fls_tgt [`ROB_LANES],
   input  lane_cnt_t pop_size
);

   bank_idx_t head_bank;
   bank_idx_t tail_bank;
   logic      bank_push [`ROB_LANES];
   logic      bank_pop [`ROB_LANES];
   logic      bank_full [`ROB_LANES];
   logic      bank_valid [`ROB_LANES];
   logic      bank_done [`ROB_LANES];
   slot_idx_t bank_wptr [`ROB_LANES];
   // Issue data after rotation onto banks
   pc_t       bank_pc [`ROB_LANES];
   lreg_t     bank_lrd [`ROB_LANES];
   preg_t     bank_prd [`ROB_LANES];
   logic      bank_prd_we [`ROB_LANES];
   preg_t     bank_pfree [`ROB_LANES];
   // Head entry of each bank
   pc_t       head_pc [`ROB_LANES];
   lreg_t     head_lrd [`ROB_LANES];
   preg_t     head_prd [`ROB_LANES];
   logic      head_prd_we [`ROB_LANES];
   preg_t     head_pfree [`ROB_LANES];
   logic      head_exc [`ROB_LANES];
   logic      head_fls [`ROB_LANES];
   pc_t       head_fls_tgt [`ROB_LANES];
   // Writeback steered per bank
   logic      bank_wb_we [`ROB_LANES];
   slot_idx_t bank_wb_slot [`ROB_LANES];
   logic      bank_wb_exc [`ROB_LANES];
   logic      bank_wb_fls [`ROB_LANES];
   pc_t       bank_wb_fls_tgt [`ROB_LANES];

   // Port names match the nets above one to one
   rob_ctrl u_ctrl (.*);

   rob_lane_xbar u_xbar (.*);

   rob_wb_route u_wb_route (.*);

   rob_bank u_bank0
   (
      .clk        (clk),                .rst_n        (rst_n),
      .flush      (flush),              .push         (bank_push[0]),
      .pop        (bank_pop[0]),        .push_pc      (bank_pc[0]),
      .push_lrd   (bank_lrd[0]),        .push_prd     (bank_prd[0]),
      .push_prd_we(bank_prd_we[0]),     .push_pfree   (bank_pfree[0]),
      .wb_we      (bank_wb_we[0]),      .wb_slot      (bank_wb_slot[0]),
      .wb_exc     (bank_wb_exc[0]),     .wb_fls       (bank_wb_fls[0]),
      .wb_fls_tgt (bank_wb_fls_tgt[0]), .valid        (bank_valid[0]),
      .full       (bank_full[0]),       .done         (bank_done[0]),
      .wptr       (bank_wptr[0]),       .head_pc      (head_pc[0]),
      .head_lrd   (head_lrd[0]),        .head_prd     (head_prd[0]),
      .head_prd_we(head_prd_we[0]),     .head_pfree   (head_pfree[0]),
      .head_exc   (head_exc[0]),        .head_fls     (head_fls[0]),
      .head_fls_tgt(head_fls_tgt[0])
   );

   rob_bank u_bank1
   (
      .clk        (clk),                .rst_n        (rst_n),
      .flush      (flush),              .push         (bank_push[1]),
      .pop        (bank_pop[1]),        .push_pc      (bank_pc[1]),
      .push_lrd   (bank_lrd[1]),        .push_prd     (bank_prd[1]),
      .push_prd_we(bank_prd_we[1]),     .push_pfree   (bank_pfree[1]),
      .wb_we      (bank_wb_we[1]),      .wb_slot      (bank_wb_slot[1]),
      .wb_exc     (bank_wb_exc[1]),     .wb_fls       (bank_wb_fls[1]),
      .wb_fls_tgt (bank_wb_fls_tgt[1]), .valid        (bank_valid[1]),
      .full       (bank_full[1]),       .done         (bank_done[1]),
      .wptr       (bank_wptr[1]),       .head_pc      (head_pc[1]),
      .head_lrd   (head_lrd[1]),        .head_prd     (head_prd[1]),
      .head_prd_we(head_prd_we[1]),     .head_pfree   (head_pfree[1]),
      .head_exc   (head_exc[1]),        .head_fls     (head_fls[1]),
      .head_fls_tgt(head_fls_tgt[1])
   );

endmodule

/* rob_uop_pkg.sv */
/*
 Field types of one reorder buffer entry.
 Shared by the banks, the crossbar and the writeback routing.
*/
`include "rob_defines.svh"

package rob_uop_pkg;

   // Instruction address, also used for the flush target
   typedef logic [`ROB_PC_W-1:0] pc_t;

   typedef logic [`ROB_LRF_AW-1:0] lreg_t;

   typedef logic [`ROB_PRF_AW-1:0] preg_t;

endpackage

/* rob_wb_route.sv */
/*
 Writeback port arbitration and steering for the reorder buffer banks.
 An older port wins a shared bank; the refused port holds and retries.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module rob_wb_route
   import rob_geom_pkg::*;
   import rob_uop_pkg::*;
(
   input  logic      wb_valid [`ROB_LANES],
   input  bank_idx_t wb_bank [`ROB_LANES],
   input  slot_idx_t wb_id [`ROB_LANES],
   input  logic      wb_exc [`ROB_LANES],
   input  logic      wb_fls [`ROB_LANES],
   input  pc_t       wb_fls_tgt [`ROB_LANES],
   output logic      wb_rob_ready [`ROB_LANES],
   output logic      bank_wb_we [`ROB_LANES],
   output slot_idx_t bank_wb_slot [`ROB_LANES],
   output logic      bank_wb_exc [`ROB_LANES],
   output logic      bank_wb_fls [`ROB_LANES],
   output pc_t       bank_wb_fls_tgt [`ROB_LANES]
);

   logic wb_acc [`ROB_LANES];

   // Refuse a port when an older valid port hits the same bank
   always_comb
   begin
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         wb_rob_ready[i] = 1'b1;
         for (int j = 0; j < i; j++)
            if (wb_valid[j] && (wb_bank[j] == wb_bank[i]))
               wb_rob_ready[i] = 1'b0;
         wb_acc[i] = wb_valid[i] & wb_rob_ready[i];
      end
   end

   always_comb
   begin
      for (int b = 0; b < `ROB_LANES; b++)
      begin
         bank_wb_we[b]      = 1'b0;
         bank_wb_slot[b]    = '0;
         bank_wb_exc[b]     = 1'b0;
         bank_wb_fls[b]     = 1'b0;
         bank_wb_fls_tgt[b] = '0;
         for (int j = 0; j < `ROB_LANES; j++)
            if (wb_acc[j] && (wb_bank[j] == bank_idx_t'(b)))
            begin
               bank_wb_we[b]      = 1'b1;
               bank_wb_slot[b]    = wb_id[j];
               bank_wb_exc[b]     = wb_exc[j];
               bank_wb_fls[b]     = wb_fls[j];
               bank_wb_fls_tgt[b] = wb_fls_tgt[j];
            end
      end
   end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Builds the reorder buffer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_rob -f tb.f -Mdir obj_dir > "$build_log" 2>&1
if [ $? -ne 0 ]; then
   echo "Verilator build failed, see $build_log"
   exit 1
fi

./obj_dir/Vtb_rob > "$sim_log" 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status, see $sim_log"
   exit 1
fi

if grep -qx "sim passed" "$sim_log"; then
   echo "PASS"
   exit 0
else
   echo "FAIL, see $sim_log"
   exit 1
fi

/* tb.f */
+incdir+.
rob_geom_pkg.sv
rob_uop_pkg.sv
rob_ctrl.sv
rob_lane_xbar.sv
rob_wb_route.sv
rob_bank.sv
rob_top.sv
tb_rob.sv

/* tb_rob.sv */
/*
 Testbench for the banked reorder buffer.
 Replays rob_stim.txt one row per clock and checks every expected output of the row.
*/
`timescale 1ns/1ps
`include "rob_defines.svh"

module tb_rob
   import rob_geom_pkg::*;
   import rob_uop_pkg::*;
();

   localparam int MAX_ROWS = 64;
   // Hex words per stimulus row
   localparam int COLS     = 14;

   logic      clk;
   logic      rst_n;
   logic      flush;
   lane_cnt_t push_size;
   pc_t       push_pc [`ROB_LANES];
   lreg_t     push_lrd [`ROB_LANES];
   preg_t     push_prd [`ROB_LANES];
   logic      push_prd_we [`ROB_LANES];
   preg_t     push_pfree [`ROB_LANES];
   logic      rob_ready;
   bank_idx_t free_bank [`ROB_LANES];
   slot_idx_t free_id [`ROB_LANES];
   logic      wb_valid [`ROB_LANES];
   bank_idx_t wb_bank [`ROB_LANES];
   slot_idx_t wb_id [`ROB_LANES];
   logic      wb_exc [`ROB_LANES];
   logic      wb_fls [`ROB_LANES];
   pc_t       wb_fls_tgt [`ROB_LANES];
   logic      wb_rob_ready [`ROB_LANES];
   logic      cmt_valid [`ROB_LANES];
   pc_t       cmt_pc [`ROB_LANES];
   lreg_t     cmt_lrd [`ROB_LANES];
   preg_t     cmt_prd [`ROB_LANES];
   logic      cmt_prd_we [`ROB_LANES];
   preg_t     cmt_pfree [`ROB_LANES];
   logic      cmt_exc [`ROB_LANES];
   logic      cmt_fls [`ROB_LANES];
   pc_t       cmt_fls_tgt [`ROB_LANES];
   lane_cnt_t pop_size;

   logic [31:0] stim [MAX_ROWS*COLS];
   int num_rows;
   int limit;
   int cycles;
   int step;

   rob_top DUT (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Hang guard, counted in clock cycles
   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (limit > 0 && cycles >= limit)
      begin
         $display("timeout: stimulus did not finish within %0d cycles", limit);
         $display("sim failed");
         $fatal(1, "timeout");
      end
   end

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("FAILED %s at row %0d: got 0x%h, expected 0x%h", name, step, got, exp);
         $display("sim failed");
         $fatal(1, "output mismatch");
      end
   endtask

   // Register fields of an entry follow from its pc
   function automatic lreg_t lrd_of(input pc_t pc);
      return lreg_t'(pc >> 2);
   endfunction

   function automatic preg_t prd_of(input pc_t pc);
      return preg_t'(pc >> 3);
   endfunction

   function automatic logic prd_we_of(input pc_t pc);
      return pc[2];
   endfunction

   function automatic preg_t pfree_of(input pc_t pc);
      return preg_t'(pc >> 4);
   endfunction

   // Row layout is c pc0 pc1 w0 t0 w1 t1 xa xf ce cp0 cp1 ct0 ct1
   task automatic drive_row(input int r);
      logic [31:0] c;
      logic [31:0] w;
      int base;
      base      = r * COLS;
      c         = stim[base];
      flush     = c[8];
      push_size = lane_cnt_t'(c[7:4]);
      pop_size  = lane_cnt_t'(c[3:0]);
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         // Register fields only ride along, derived from the pc
         push_pc[i]     = stim[base + 1 + i];
         push_lrd[i]    = lrd_of(push_pc[i]);
         push_prd[i]    = prd_of(push_pc[i]);
         push_prd_we[i] = prd_we_of(push_pc[i]);
         push_pfree[i]  = pfree_of(push_pc[i]);
         w              = stim[base + 3 + 2*i];
         wb_valid[i]    = w[16];
         wb_bank[i]     = bank_idx_t'(w[15:12]);
         wb_id[i]       = slot_idx_t'(w[11:8]);
         wb_exc[i]      = w[4];
         wb_fls[i]      = w[0];
         wb_fls_tgt[i]  = stim[base + 4 + 2*i];
      end
   endtask

   task automatic check_row(input int r);
      logic [31:0] xa;
      logic [31:0] xf;
      logic [31:0] ce;
      pc_t cp;
      int base;
      base = r * COLS;
      xa   = stim[base + 7];
      xf   = stim[base + 8];
      ce   = stim[base + 9];
      check_val("rob_ready", rob_ready, xa[8]);
      check_val("wb_rob_ready[0]", wb_rob_ready[0], xa[4]);
      check_val("wb_rob_ready[1]", wb_rob_ready[1], xa[0]);
      check_val("free_bank[0]", free_bank[0], xf[15:12]);
      check_val("free_id[0]", free_id[0], xf[11:8]);
      check_val("free_bank[1]", free_bank[1], xf[7:4]);
      check_val("free_id[1]", free_id[1], xf[3:0]);
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         check_val($sformatf("cmt_valid[%0d]", i), cmt_valid[i], ce[20 - 4*i]);
         // Entry fields only mean something on a valid lane
         if (ce[20 - 4*i])
         begin
            cp = stim[base + 10 + i];
            check_val($sformatf("cmt_pc[%0d]", i), cmt_pc[i], cp);
            check_val($sformatf("cmt_lrd[%0d]", i), cmt_lrd[i], lrd_of(cp));
            check_val($sformatf("cmt_prd[%0d]", i), cmt_prd[i], prd_of(cp));
            check_val($sformatf("cmt_prd_we[%0d]", i), cmt_prd_we[i], prd_we_of(cp));
            check_val($sformatf("cmt_pfree[%0d]", i), cmt_pfree[i], pfree_of(cp));
            check_val($sformatf("cmt_exc[%0d]", i), cmt_exc[i], ce[12 - 8*i]);
            check_val($sformatf("cmt_fls[%0d]", i), cmt_fls[i], ce[8 - 8*i]);
            check_val($sformatf("cmt_fls_tgt[%0d]", i), cmt_fls_tgt[i], stim[base + 12 + i]);
         end
      end
   endtask

   initial
   begin
      rst_n     = 1'b0;
      flush     = 1'b0;
      push_size = '0;
      pop_size  = '0;
      for (int i = 0; i < `ROB_LANES; i++)
      begin
         push_pc[i]     = '0;
         push_lrd[i]    = '0;
         push_prd[i]    = '0;
         push_prd_we[i] = 1'b0;
         push_pfree[i]  = '0;
         wb_valid[i]    = 1'b0;
         wb_bank[i]     = '0;
         wb_id[i]       = '0;
         wb_exc[i]      = 1'b0;
         wb_fls[i]      = 1'b0;
         wb_fls_tgt[i]  = '0;
      end
      cycles   = 0;
      limit    = 0;
      $readmemh("rob_stim.txt", stim);
      // Rows run up to the end marker
      num_rows = 0;
      while (num_rows < MAX_ROWS && stim[num_rows*COLS] !== 32'hfff)
         num_rows++;
      if (num_rows == 0 || num_rows == MAX_ROWS)
      begin
         $display("stimulus file is empty or has no end marker");
         $display("sim failed");
         $fatal(1, "bad stimulus file");
      end
      limit = num_rows + 20;

      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (step = 0; step < num_rows; step++)
      begin
         drive_row(step);
         #40;
         check_row(step);
         @(posedge clk);
         #1;
      end

      $display("sim passed");
      $finish;
   end

endmodule
